/* all.f */
rv_pkg.sv
reg_file.sv
id_stage.sv
operand_fwd.sv
ex_stage.sv
mem_stage.sv
pipe_ctrl.sv
alu_pipe_top.sv
tb_clk_gen.sv
tb_alu_pipe.sv

/* tb_alu_pipe.sv */
module tb_alu_pipe;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int INSTR_TOTAL  = 4 + 30 + 54 + 44 + 80;
    localparam int WATCH_CYCLES = INSTR_TOTAL * 20;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    instr_t  in_instr;
    logic    ret_valid;
    logic    ret_ready;
    retire_t ret;

    int seed    = 32'h29d6d8aa;
    int bp_seed = 32'h29d6d8aa;  // separate stream for ret_ready toggling.
    int errors  = 0;
    int checks  = 0;
    int cyc     = 0;
    int last_wait;
    int err_mark;
    logic bp_on   = 1'b0;
    logic lat_chk = 1'b0;

    // reference model state.
    logic [XLEN-1:0] mregs [NUM_REGS];
    logic [XLEN-1:0] mmem [DMEM_WORDS];
    logic            mem_ok [DMEM_WORDS];
    retire_t         exp_q [$];
    int              acc_q [$];

    logic    hold_chk = 1'b0;
    retire_t held_ret;

    opcode_e reg_ops [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                             OP_SLL, OP_SRL, OP_SRA, OP_SLT};

    tb_clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    alu_pipe_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .ret_valid (ret_valid),
        .ret_ready (ret_ready),
        .ret       (ret)
    );

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic instr_t mk(input opcode_e op, input int rd, input int rs1,
                                  input int rs2, input int imm);
        instr_t i;
        i.op  = op;
        i.rd  = rd[REG_AW-1:0];
        i.rs1 = rs1[REG_AW-1:0];
        i.rs2 = rs2[REG_AW-1:0];
        i.imm = imm;
        return i;
    endfunction

    // sequential semantics, applied in program order at acceptance.
    task automatic model_accept(input instr_t ins);
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [XLEN-1:0]    immx;
        logic [XLEN-1:0]    v;
        logic [DMEM_AW-1:0] wa;
        retire_t            r;
        a    = mregs[ins.rs1];
        b    = mregs[ins.rs2];
        immx = {{(XLEN-IMM_W){ins.imm[IMM_W-1]}}, ins.imm};
        wa   = (a + immx) >> 3;
        case (ins.op)
            OP_ADD:  v = a + b;
            OP_SUB:  v = a - b;
            OP_AND:  v = a & b;
            OP_OR:   v = a | b;
            OP_XOR:  v = a ^ b;
            OP_SLL:  v = a << b[5:0];
            OP_SRL:  v = a >> b[5:0];
            OP_SRA:  v = $signed(a) >>> b[5:0];
            OP_SLT:  v = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_ADDI: v = a + immx;
            OP_LD:   v = mmem[wa];
            default: begin
                mmem[wa]   = b;
                mem_ok[wa] = 1'b1;
                v          = b;
            end
        endcase
        r.rd    = ins.rd;
        r.wr_en = (ins.op != OP_SD) && (ins.rd != 0);
        r.value = v;
        if (r.wr_en) begin
            mregs[ins.rd] = v;
        end
        exp_q.push_back(r);
        acc_q.push_back(cyc);
    endtask

    // called 10 ns after an edge, returns 10 ns after the accepting edge.
    task automatic send(input instr_t ins);
        int w;
        w        = 0;
        in_instr = ins;
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            w++;
            @(posedge clk);
        end
        model_accept(ins);
        last_wait = w;
        #10;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
        #10;
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s: finished with %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ret_ready toggles randomly during the back-pressure test.
    initial begin
        forever begin
            @(posedge clk);
            #10;
            if (bp_on) begin
                ret_ready = $random(bp_seed) & 1;
            end
        end
    end

    always @(posedge clk) begin : retire_mon
        retire_t e;
        int      t;
        if (rst_n) begin
            if (hold_chk) begin
                assert (ret_valid) else begin
                    $display("Error: ret_valid expected 1 got %h while stalled", ret_valid);
                    errors++;
                end
                assert (ret == held_ret) else begin
                    $display("Error: ret expected %h got %h while stalled", held_ret, ret);
                    errors++;
                end
            end
            hold_chk = ret_valid && !ret_ready;
            held_ret = ret;
            if (ret_valid && ret_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("a record retired with no instruction outstanding");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    t = acc_q.pop_front();
                    checks++;
                    assert (ret.rd == e.rd) else begin
                        $display("Error: ret.rd expected %h got %h", e.rd, ret.rd);
                        errors++;
                    end
                    assert (ret.wr_en == e.wr_en) else begin
                        $display("Error: ret.wr_en expected %h got %h", e.wr_en, ret.wr_en);
                        errors++;
                    end
                    assert (ret.value == e.value) else begin
                        $display("Error: ret.value expected %h got %h", e.value, ret.value);
                        errors++;
                    end
                    if (lat_chk) begin
                        assert (cyc - t == 4) else begin
                            $display("instruction accepted at cycle %0d retired %0d cycles later",
                                     t, cyc - t);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        #(WATCH_CYCLES * 100);
        $display("timeout: the pipeline stopped retiring instructions");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int dep;
        int oth;
        int a;
        int k;
        instr_t ins;
        in_valid  = 1'b0;
        in_instr  = '0;
        ret_ready = 1'b1;
        err_mark  = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mmem[i]   = '0;
            mem_ok[i] = 1'b0;
        end
        wait (rst_n);
        @(posedge clk);
        #10;

        // reset state, then reads of untouched registers.
        assert (!ret_valid) else begin
            $display("Error: ret_valid expected 0 got %h after reset", ret_valid);
            errors++;
        end
        assert (in_ready) else begin
            $display("Error: in_ready expected 1 got %h after reset", in_ready);
            errors++;
        end
        lat_chk = 1'b1;
        send(mk(OP_ADD, 1, 2, 3, 0));
        send(mk(OP_ADDI, 4, 0, 0, 5));
        send(mk(OP_SUB, 5, 0, 4, 0));
        send(mk(OP_OR, 6, 7, 8, 0));
        drain();
        report(1, "reset");

        for (int r = 1; r <= 8; r++) begin
            send(mk(OP_ADDI, r, 0, 0, $random(seed)));
        end
        for (int j = 0; j < 10; j++) begin
            for (int n = 0; n < 2; n++) begin
                send(mk((j == 9) ? OP_ADDI : reg_ops[j], 9 + pick(16), 1 + pick(8),
                        1 + pick(8), $random(seed)));
            end
        end
        send(mk(OP_ADD, 0, 1, 2, 0));
        send(mk(OP_ADD, 20, 0, 1, 0));
        drain();
        lat_chk = 1'b0;
        report(2, "alu ops");

        for (int d = 1; d <= 3; d++) begin
            for (int m = 0; m < 3; m++) begin
                for (int c = 0; c < 6; c++) begin
                    dep = (c >= d) ? 9 + c - d : 1 + pick(8);
                    oth = 1 + pick(8);
                    send(mk(reg_ops[pick(9)], 9 + c, (m != 1) ? dep : oth,
                            (m != 0) ? dep : oth, 0));
                end
            end
        end
        drain();
        report(3, "forwarding");

        for (int i = 0; i < 8; i++) begin
            send(mk(OP_SD, 0, 0, 1 + i, i * 8));
        end
        for (int i = 0; i < 6; i++) begin
            a = 8 + pick(56);
            send(mk(OP_SD, 0, 0, 1 + i, a * 8));
            send(mk(OP_LD, 16 + i, 0, 0, a * 8));
            send(mk(OP_LD, 22 + i, 0, 0, pick(8) * 8));
        end
        for (int i = 0; i < 4; i++) begin
            send(mk(OP_LD, 26, 0, 0, i * 8));
            if (i % 2 == 0) begin
                send(mk(OP_ADD, 27, 26, 1, 0));
            end else begin
                send(mk(OP_SUB, 27, 1, 26, 0));
            end
            send(mk(OP_ADDI, 28, 0, 0, i));
            assert (last_wait == 1) else begin
                $display("load-use stall lasted %0d cycles instead of one", last_wait);
                errors++;
            end
        end
        for (int i = 0; i < 2; i++) begin
            send(mk(OP_LD, 26, 0, 0, i * 8));
            send(mk(OP_ADD, 27, 1, 2, 0));
            send(mk(OP_ADDI, 28, 0, 0, i));
            assert (last_wait == 0) else begin
                $display("independent instruction after a load stalled %0d cycles", last_wait);
                errors++;
            end
        end
        drain();
        report(4, "loads and stores");

        bp_on = 1'b1;
        for (int n = 0; n < 80; n++) begin
            k = pick(12);
            if (k < 9) begin
                ins = mk(reg_ops[k], pick(32), pick(32), pick(32), 0);
            end else if (k == 9) begin
                ins = mk(OP_ADDI, pick(32), pick(32), 0, $random(seed));
            end else begin
                a = pick(DMEM_WORDS);
                if (k == 10 && mem_ok[a]) begin
                    ins = mk(OP_LD, pick(32), 0, 0, a * 8);
                end else begin
                    ins = mk(OP_SD, 0, 0, pick(32), a * 8);
                end
            end
            send(ins);
        end
        bp_on = 1'b0;
        ret_ready = 1'b1;
        drain();
        report(5, "back-pressure");

        $display("retire checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

/* alu_pipe_top.sv */
module alu_pipe_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  rv_pkg::instr_t  in_instr,
    output logic            ret_valid,
    input  logic            ret_ready,
    output rv_pkg::retire_t ret
);
    import rv_pkg::*;

    logic              advance;
    logic              bubble;
    logic              id_valid;
    logic              ex_valid;
    logic              mem_valid;
    logic              id_load;
    logic              ex_is_load;
    logic              rf_wr_en;
    logic [REG_AW-1:0] ex_rd;
    logic [XLEN-1:0]   rf_rd1;
    logic [XLEN-1:0]   rf_rd2;
    instr_t            id_instr;
    idex_t             id_rec;
    exmem_t            exm_rec;

    assign id_load  = in_valid && advance && !bubble;  // id holds through a bubble.
    assign rf_wr_en = ret_valid && ret_ready && ret.wr_en;

    pipe_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .id_rs1     (id_instr.rs1),
        .id_rs2     (id_instr.rs2),
        .ex_is_load (ex_is_load),
        .ex_rd      (ex_rd),
        .ret_ready  (ret_ready),
        .ret_valid  (ret_valid),
        .id_valid   (id_valid),
        .ex_valid   (ex_valid),
        .mem_valid  (mem_valid),
        .advance    (advance),
        .bubble     (bubble)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd1_addr (id_instr.rs1),
        .rd2_addr (id_instr.rs2),
        .rd1_data (rf_rd1),
        .rd2_data (rf_rd2),
        .wr_en    (rf_wr_en),
        .wr_addr  (ret.rd),
        .wr_data  (ret.value)
    );

    id_stage u_id (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_en  (id_load),
        .in_instr (in_instr),
        .rf_rd1   (rf_rd1),
        .rf_rd2   (rf_rd2),
        .id_rec   (id_rec),
        .id_instr (id_instr)
    );

    ex_stage u_ex (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .ex_valid   (ex_valid),
        .mem_valid  (mem_valid),
        .wb_valid   (ret_valid),
        .id_rec     (id_rec),
        .wb_rec     (ret),
        .exm_rec    (exm_rec),
        .ex_is_load (ex_is_load),
        .ex_rd      (ex_rd)
    );

    mem_stage u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .mem_valid (mem_valid),
        .exm_rec   (exm_rec),
        .ret       (ret)
    );

endmodule

/* pipe_ctrl.sv */
module pipe_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [rv_pkg::REG_AW-1:0] id_rs1,
    input  logic [rv_pkg::REG_AW-1:0] id_rs2,
    input  logic                      ex_is_load,
    input  logic [rv_pkg::REG_AW-1:0] ex_rd,
    input  logic                      ret_ready,
    output logic                      ret_valid,
    output logic                      id_valid,
    output logic                      ex_valid,
    output logic                      mem_valid,
    output logic                      advance,
    output logic                      bubble
);

    logic rd_hit;
    logic load_use;

    // retire port stalled, so the whole pipe freezes.
    assign advance = !(ret_valid && !ret_ready);

    assign rd_hit   = (ex_rd != '0) && ((ex_rd == id_rs1) || (ex_rd == id_rs2));
    assign load_use = id_valid && ex_is_load && rd_hit;

    assign bubble   = advance && load_use;
    assign in_ready = advance && !load_use;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            ret_valid <= 1'b0;
        end else if (advance) begin
            ret_valid <= mem_valid;
            mem_valid <= ex_valid;
            ex_valid  <= id_valid && !bubble;  // hole behind the load.
            if (!bubble) begin
                id_valid <= in_valid;
            end
        end
    end

endmodule

/* mem_stage.sv */
module mem_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            advance,
    input  logic            mem_valid,
    input  rv_pkg::exmem_t  exm_rec,
    output rv_pkg::retire_t ret
);
    import rv_pkg::*;

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] addr;
    logic [XLEN-1:0]    rdata;
    logic [XLEN-1:0]    wb_value;
    logic               st_en;

    assign addr  = exm_rec.result[DMEM_AW+2:3];  // doubleword index.
    assign rdata = dmem[addr];
    assign st_en = advance && mem_valid && (exm_rec.op == OP_SD);

    always_ff @(posedge clk) begin
        if (st_en) begin
            dmem[addr] <= exm_rec.store_data;
        end
    end

    always_comb begin
        case (exm_rec.op)
            OP_LD:   wb_value = rdata;
            OP_SD:   wb_value = exm_rec.store_data;  // reported on retire, not written back.
            default: wb_value = exm_rec.result;
        endcase
    end

    // mem/wb register, its output is the retire record.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret <= '0;
        end else if (advance) begin
            ret.rd    <= exm_rec.rd;
            ret.wr_en <= mem_valid && exm_rec.wr_en;
            ret.value <= wb_value;
        end
    end

endmodule

/* ex_stage.sv */
module ex_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      advance,
    input  logic                      ex_valid,
    input  logic                      mem_valid,
    input  logic                      wb_valid,
    input  rv_pkg::idex_t             id_rec,
    input  rv_pkg::retire_t           wb_rec,
    output rv_pkg::exmem_t            exm_rec,
    output logic                      ex_is_load,
    output logic [rv_pkg::REG_AW-1:0] ex_rd
);
    import rv_pkg::*;

    idex_t              ex_q;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [XLEN-1:0]    imm_ext;
    logic [XLEN-1:0]    alu_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else if (advance) begin
            ex_q <= id_rec;
        end
    end

    operand_fwd u_fwd (
        .rs1       (ex_q.rs1),
        .rs2       (ex_q.rs2),
        .rs1_val   (ex_q.rs1_val),
        .rs2_val   (ex_q.rs2_val),
        .exm_valid (mem_valid),
        .exm_rec   (exm_rec),
        .wb_valid  (wb_valid),
        .wb_rec    (wb_rec),
        .op_a      (op_a),
        .op_b      (op_b)
    );

    assign imm_ext = {{(XLEN-IMM_W){ex_q.imm[IMM_W-1]}}, ex_q.imm};
    assign alu_b   = (ex_q.op inside {OP_ADDI, OP_LD, OP_SD}) ? imm_ext : op_b;
    assign shamt   = alu_b[SHAMT_W-1:0];

    always_comb begin
        case (ex_q.op)
            OP_ADD, OP_ADDI, OP_LD, OP_SD: alu_res = op_a + alu_b;  // loads and stores form the address.
            OP_SUB:  alu_res = op_a - alu_b;
            OP_AND:  alu_res = op_a & alu_b;
            OP_OR:   alu_res = op_a | alu_b;
            OP_XOR:  alu_res = op_a ^ alu_b;
            OP_SLL:  alu_res = op_a << shamt;
            OP_SRL:  alu_res = op_a >> shamt;
            OP_SRA:  alu_res = $signed(op_a) >>> shamt;
            OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exm_rec <= '0;
        end else if (advance) begin
            exm_rec.op         <= ex_q.op;
            exm_rec.rd         <= ex_q.rd;
            exm_rec.wr_en      <= ex_valid && ex_q.wr_en;  // empty slot writes nothing.
            exm_rec.result     <= alu_res;
            exm_rec.store_data <= op_b;
        end
    end

    assign ex_is_load = ex_valid && (ex_q.op == OP_LD);
    assign ex_rd      = ex_q.rd;

endmodule

/* operand_fwd.sv */
module operand_fwd (
    input  logic [rv_pkg::REG_AW-1:0] rs1,
    input  logic [rv_pkg::REG_AW-1:0] rs2,
    input  logic [rv_pkg::XLEN-1:0]   rs1_val,
    input  logic [rv_pkg::XLEN-1:0]   rs2_val,
    input  logic                      exm_valid,
    input  rv_pkg::exmem_t            exm_rec,
    input  logic                      wb_valid,
    input  rv_pkg::retire_t           wb_rec,
    output logic [rv_pkg::XLEN-1:0]   op_a,
    output logic [rv_pkg::XLEN-1:0]   op_b
);
    import rv_pkg::*;

    logic exm_src_ok;
    logic wb_src_ok;

    // a load in ex/mem only holds its address, its data comes later from mem/wb.
    assign exm_src_ok = exm_valid && exm_rec.wr_en && (exm_rec.op != OP_LD);
    assign wb_src_ok  = wb_valid && wb_rec.wr_en;

    // youngest producer wins. wr_en is never set for x0, so x0 keeps its read value.
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_AW-1:0] rs,
        input logic [XLEN-1:0]   rf_val
    );
        if (exm_src_ok && exm_rec.rd == rs) begin
            return exm_rec.result;
        end
        if (wb_src_ok && wb_rec.rd == rs) begin
            return wb_rec.value;
        end
        return rf_val;
    endfunction

    always_comb begin
        op_a = pick(rs1, rs1_val);
        op_b = pick(rs2, rs2_val);
    end

endmodule

/* id_stage.sv */
module id_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_en,
    input  rv_pkg::instr_t          in_instr,
    input  logic [rv_pkg::XLEN-1:0] rf_rd1,
    input  logic [rv_pkg::XLEN-1:0] rf_rd2,
    output rv_pkg::idex_t           id_rec,
    output rv_pkg::instr_t          id_instr
);
    import rv_pkg::*;

    instr_t instr_n;
    instr_t instr_q;

    // addi and ld carry no rs2, clear it so no false hazard is seen.
    always_comb begin
        instr_n = in_instr;
        if (in_instr.op inside {OP_ADDI, OP_LD}) begin
            instr_n.rs2 = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q <= '0;
        end else if (load_en) begin
            instr_q <= instr_n;
        end
    end

    assign id_instr = instr_q;  // addresses for the register file and hazard check.

    always_comb begin
        id_rec.op      = instr_q.op;
        id_rec.rd      = instr_q.rd;
        id_rec.rs1     = instr_q.rs1;
        id_rec.rs2     = instr_q.rs2;
        id_rec.imm     = instr_q.imm;
        id_rec.rs1_val = rf_rd1;
        id_rec.rs2_val = rf_rd2;
        id_rec.wr_en   = (instr_q.op != OP_SD) && (instr_q.rd != '0);  // x0 never written.
    end

endmodule

/* reg_file.sv */
module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [rv_pkg::REG_AW-1:0] rd1_addr,
    input  logic [rv_pkg::REG_AW-1:0] rd2_addr,
    output logic [rv_pkg::XLEN-1:0]   rd1_data,
    output logic [rv_pkg::XLEN-1:0]   rd2_data,
    input  logic                      wr_en,
    input  logic [rv_pkg::REG_AW-1:0] wr_addr,
    input  logic [rv_pkg::XLEN-1:0]   wr_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr_addr == addr) begin
            return wr_data;  // same-edge write passes straight through.
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd1_data = read_port(rd1_addr);
        rd2_data = read_port(rd2_addr);
    end

endmodule

/* rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int REG_AW     = 5;
    localparam int NUM_REGS   = 1 << REG_AW;
    localparam int DMEM_AW    = 6;
    localparam int DMEM_WORDS = 1 << DMEM_AW;
    localparam int IMM_W      = 32;
    localparam int SHAMT_W    = $clog2(XLEN);

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_ADDI = 4'd9,
        OP_LD   = 4'd10,
        OP_SD   = 4'd11
    } opcode_e;

    // decoded instruction as it enters the pipe.
    typedef struct packed {
        opcode_e                 op;
        logic [REG_AW-1:0]       rd;
        logic [REG_AW-1:0]       rs1;
        logic [REG_AW-1:0]       rs2;
        logic signed [IMM_W-1:0] imm;
    } instr_t;

    typedef struct packed {
        opcode_e                 op;
        logic [REG_AW-1:0]       rd;
        logic [REG_AW-1:0]       rs1;
        logic [REG_AW-1:0]       rs2;
        logic signed [IMM_W-1:0] imm;
        logic [XLEN-1:0]         rs1_val;
        logic [XLEN-1:0]         rs2_val;
        logic                    wr_en;   // writes a register other than x0.
    } idex_t;

    typedef struct packed {
        opcode_e           op;
        logic [REG_AW-1:0] rd;
        logic              wr_en;
        logic [XLEN-1:0]   result;      // alu result or memory byte address.
        logic [XLEN-1:0]   store_data;
    } exmem_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              wr_en;
        logic [XLEN-1:0]   value;
    } retire_t;

endpackage
